//--- parser_pkg.sv
// header buffer geometry; four slots of 64 big-endian words, byte 0 is the top byte of word 0
package parser_pkg;

	// one header word as it arrives on the stream
	typedef logic [31:0] word_t;

	// buffer slot, one header per slot
	typedef logic [1:0] slot_t;

	// word index inside one slot
	typedef logic [5:0] word_idx_t;

	// full buffer address, slot on top of word index
	typedef logic [7:0] buf_addr_t;

	// byte position inside a slot's header, word index in bits 7:2
	typedef logic [7:0] byte_pos_t;

	// bytes per header word, also the step between fields
	localparam byte_pos_t WORD_BYTES = 8'd4;

	// words per slot
	localparam int SLOT_WORDS = 64;

	// slots in the buffer
	localparam int NUM_SLOTS = 4;

endpackage

//--- extract_cmd_pkg.sv
// extraction command fields; count must be 1 to MAX_FIELDS, no range checks on start or base here
package extract_cmd_pkg;

	// packet id carried from command to done pulse
	typedef logic [7:0] pkt_id_t;

	// header-vector offset of one extracted field
	typedef logic [6:0] hv_offset_t;

	// fields requested by one command
	typedef logic [5:0] field_count_t;

	// largest legal field count per command
	localparam field_count_t MAX_FIELDS = 6'd32;

endpackage

//--- loc_if.sv
// location record link; valid/ready handshake, record held stable until accepted
`timescale 1ns/10ps

interface loc_if;
	import parser_pkg::*;
	import extract_cmd_pkg::*;

	logic valid;
	logic ready;
	// end record, carries only the packet id
	logic is_end;
	slot_t slot;
	pkt_id_t pkt_id;
	byte_pos_t byte_pos;
	hv_offset_t hv_offset;

	modport gen (
		output valid, is_end, slot, pkt_id, byte_pos, hv_offset,
		input ready
	);

	modport pipe (
		input valid, is_end, slot, pkt_id, byte_pos, hv_offset,
		output ready
	);

endinterface

//--- header_buffer.sv
// header store; no back-pressure, hdr_slot held for a whole header, at most 64 words per header
`timescale 1ns/10ps

module header_buffer (
	input logic clk,
	input logic reset,
	input logic hdr_valid,
	input parser_pkg::word_t hdr_data,
	input parser_pkg::slot_t hdr_slot,
	input logic hdr_last,
	input logic rd_en,
	input parser_pkg::buf_addr_t rd_addr,
	output parser_pkg::word_t rd_data
);
	import parser_pkg::*;

	word_t mem [NUM_SLOTS * SLOT_WORDS];

	// index of the next word in the current header
	word_idx_t wr_idx;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wr_idx <= '0;
		end else if (hdr_valid) begin
			// a last word restarts the next header at index 0
			if (hdr_last)
				wr_idx <= '0;
			else
				wr_idx <= wr_idx + 1'b1;
		end
	end

	// write port from the stream, registered read port
	always_ff @(posedge clk) begin
		if (hdr_valid)
			mem[{hdr_slot, wr_idx}] <= hdr_data;
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

	// a header longer than one slot would overwrite its own first words
	assert property (@(posedge clk) disable iff (!reset)
		hdr_valid && wr_idx == word_idx_t'(SLOT_WORDS - 1) |-> hdr_last)
		else $error("header overran its slot");

endmodule

//--- location_gen.sv
// command expander; one command at a time, no check that start + 4*count stays inside the header
`timescale 1ns/10ps

module location_gen (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	output logic cmd_ready,
	input parser_pkg::slot_t cmd_slot,
	input extract_cmd_pkg::pkt_id_t cmd_pkt_id,
	input parser_pkg::byte_pos_t cmd_start,
	input extract_cmd_pkg::field_count_t cmd_count,
	input extract_cmd_pkg::hv_offset_t cmd_hv_base,
	loc_if.gen loc
);
	import parser_pkg::*;
	import extract_cmd_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_fields,
		st_end
	} gen_state_t;

	gen_state_t state;

	// field records still to hand over, including the one on loc
	field_count_t remaining;

	logic cmd_fire;
	logic loc_fire;

	assign cmd_fire = cmd_valid && cmd_ready;
	assign loc_fire = loc.valid && loc.ready;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_idle;
			cmd_ready <= 1'b0;
			loc.valid <= 1'b0;
			remaining <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (cmd_fire) begin
						cmd_ready <= 1'b0;
						loc.valid <= 1'b1;
						remaining <= cmd_count;
						state <= st_fields;
					end else begin
						cmd_ready <= 1'b1;
					end
				end
				st_fields: begin
					if (loc_fire) begin
						remaining <= remaining - 1'b1;
						if (remaining == field_count_t'(1))
							state <= st_end;
					end
				end
				st_end: begin
					// end record taken, free for the next command
					if (loc_fire) begin
						loc.valid <= 1'b0;
						cmd_ready <= 1'b1;
						state <= st_idle;
					end
				end
				default: begin
					loc.valid <= 1'b0;
					state <= st_idle;
				end
			endcase
		end
	end

	// record payload, only meaningful while loc.valid is high
	always_ff @(posedge clk) begin
		if (state == st_idle && cmd_fire) begin
			loc.slot <= cmd_slot;
			loc.pkt_id <= cmd_pkt_id;
			loc.byte_pos <= cmd_start;
			loc.hv_offset <= cmd_hv_base;
			loc.is_end <= 1'b0;
		end else if (state == st_fields && loc_fire) begin
			// next field sits one word further on
			loc.byte_pos <= loc.byte_pos + WORD_BYTES;
			loc.hv_offset <= loc.hv_offset + 1'b1;
			loc.is_end <= (remaining == field_count_t'(1));
		end
	end

	assert property (@(posedge clk) disable iff (!reset)
		loc.valid && !loc.ready |=> loc.valid &&
		$stable({loc.is_end, loc.slot, loc.pkt_id, loc.byte_pos, loc.hv_offset}))
		else $error("location record changed before it was accepted");

	assert property (@(posedge clk) disable iff (!reset)
		cmd_fire |-> cmd_count != '0 && cmd_count <= MAX_FIELDS)
		else $error("command field count out of range");

endmodule

//--- field_pipe.sv
// field aligner; takes one record per two cycles, outputs have no back-pressure
`timescale 1ns/10ps

module field_pipe (
	input logic clk,
	input logic reset,
	loc_if.pipe loc,
	output logic rd_en,
	output parser_pkg::buf_addr_t rd_addr,
	input parser_pkg::word_t rd_data,
	output logic field_valid,
	output parser_pkg::word_t field,
	output extract_cmd_pkg::hv_offset_t field_hv_offset,
	output logic done_valid,
	output extract_cmd_pkg::pkt_id_t done_pkt_id
);
	import parser_pkg::*;
	import extract_cmd_pkg::*;

	logic fld_fire;
	logic end_fire;
	slot_t rd_slot;
	word_idx_t rd_idx;

	// staging, index 0 is the cycle after the handshake
	logic [2:0] fld_v;
	logic [2:0] end_v;
	logic [1:0] lo_q [3];
	hv_offset_t hv_q [3];
	pkt_id_t pid_q [3];

	// word holding byte_pos, kept while the next word is read
	word_t word_a;

	// four bytes starting at byte sel of word hi, continuing into word nx
	function automatic word_t align_field(word_t hi, word_t nx, logic [1:0] sel);
		word_t res;
		case (sel)
			2'd0: res = hi;
			2'd1: res = {hi[23:0], nx[31:24]};
			2'd2: res = {hi[15:0], nx[31:16]};
			default: res = {hi[7:0], nx[31:8]};
		endcase
		return res;
	endfunction

	assign fld_fire = loc.valid && loc.ready && !loc.is_end;
	assign end_fire = loc.valid && loc.ready && loc.is_end;
	assign rd_addr = {rd_slot, rd_idx};

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			loc.ready <= 1'b0;
			rd_en <= 1'b0;
			fld_v <= '0;
			end_v <= '0;
			field_valid <= 1'b0;
			done_valid <= 1'b0;
		end else begin
			// drop ready for one cycle after every accepted record
			loc.ready <= !(loc.valid && loc.ready);
			rd_en <= fld_fire || fld_v[0];
			fld_v <= {fld_v[1:0], fld_fire};
			end_v <= {end_v[1:0], end_fire};
			field_valid <= fld_v[2];
			done_valid <= end_v[2];
		end
	end

	always_ff @(posedge clk) begin
		// first read at the word of byte_pos, second at the word after it
		if (fld_fire) begin
			rd_slot <= loc.slot;
			rd_idx <= loc.byte_pos[7:2];
		end else if (fld_v[0]) begin
			rd_idx <= rd_idx + 1'b1;
		end
		lo_q[0] <= loc.byte_pos[1:0];
		hv_q[0] <= loc.hv_offset;
		pid_q[0] <= loc.pkt_id;
		lo_q[1] <= lo_q[0];
		hv_q[1] <= hv_q[0];
		pid_q[1] <= pid_q[0];
		lo_q[2] <= lo_q[1];
		hv_q[2] <= hv_q[1];
		pid_q[2] <= pid_q[1];
		if (fld_v[1])
			word_a <= rd_data;
		// rd_data now holds the second word
		if (fld_v[2]) begin
			field <= align_field(word_a, rd_data, lo_q[2]);
			field_hv_offset <= hv_q[2];
		end
		if (end_v[2])
			done_pkt_id <= pid_q[2];
	end

	assert property (@(posedge clk) disable iff (!reset) !(field_valid && done_valid))
		else $error("field and done pulses overlap");

endmodule

//--- extractor_top.sv
// extractor top; headers must be written before a command reads them, cmd_ready is the only back-pressure
`timescale 1ns/10ps

module extractor_top (
	input logic clk,
	input logic reset,
	input logic hdr_valid,
	input parser_pkg::word_t hdr_data,
	input parser_pkg::slot_t hdr_slot,
	input logic hdr_last,
	input logic cmd_valid,
	output logic cmd_ready,
	input parser_pkg::slot_t cmd_slot,
	input extract_cmd_pkg::pkt_id_t cmd_pkt_id,
	input parser_pkg::byte_pos_t cmd_start,
	input extract_cmd_pkg::field_count_t cmd_count,
	input extract_cmd_pkg::hv_offset_t cmd_hv_base,
	output logic field_valid,
	output parser_pkg::word_t field,
	output extract_cmd_pkg::hv_offset_t field_hv_offset,
	output logic done_valid,
	output extract_cmd_pkg::pkt_id_t done_pkt_id
);
	import parser_pkg::*;

	logic rd_en;
	buf_addr_t rd_addr;
	word_t rd_data;

	loc_if loc_link ();

	header_buffer u_buffer (
		.clk(clk),
		.reset(reset),
		.hdr_valid(hdr_valid),
		.hdr_data(hdr_data),
		.hdr_slot(hdr_slot),
		.hdr_last(hdr_last),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	location_gen u_gen (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_slot(cmd_slot),
		.cmd_pkt_id(cmd_pkt_id),
		.cmd_start(cmd_start),
		.cmd_count(cmd_count),
		.cmd_hv_base(cmd_hv_base),
		.loc(loc_link.gen)
	);

	field_pipe u_pipe (
		.clk(clk),
		.reset(reset),
		.loc(loc_link.pipe),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.field_valid(field_valid),
		.field(field),
		.field_hv_offset(field_hv_offset),
		.done_valid(done_valid),
		.done_pkt_id(done_pkt_id)
	);

endmodule

//--- tb_extractor.sv
// extractor testbench; every slot holds a full 64-word header before any command reads it
`timescale 1ns/10ps

module tb_extractor;
	import parser_pkg::*;
	import extract_cmd_pkg::*;

	// reset, two full buffer fills, then every command at its largest size
	localparam int NUM_CMDS = 29;
	localparam int LIMIT = 16 + 4 * NUM_SLOTS * SLOT_WORDS + NUM_CMDS * (2 * 32 + 12);

	logic clk;
	logic reset;
	logic hdr_valid;
	word_t hdr_data;
	slot_t hdr_slot;
	logic hdr_last;
	logic cmd_valid;
	logic cmd_ready;
	slot_t cmd_slot;
	pkt_id_t cmd_pkt_id;
	byte_pos_t cmd_start;
	field_count_t cmd_count;
	hv_offset_t cmd_hv_base;
	logic field_valid;
	word_t field;
	hv_offset_t field_hv_offset;
	logic done_valid;
	pkt_id_t done_pkt_id;

	word_t model [NUM_SLOTS][SLOT_WORDS];
	word_t exp_field[$];
	word_t got_field[$];
	hv_offset_t exp_hv[$];
	hv_offset_t got_hv[$];
	pkt_id_t exp_done[$];
	pkt_id_t got_done[$];
	int hs_cyc[$];
	int got_lat[$];
	logic [15:0] lfsr;
	int cyc;
	int errors;
	int err_base;
	int tests;
	int ready_busy;
	int ends;

	extractor_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == LIMIT) begin
			$display("timeout, the tests did not finish within %0d cycles", LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// collects outputs and loc handshakes, values sampled before the edge
	always @(posedge clk) begin
		if (reset) begin
			if (dut0.loc_link.valid && dut0.loc_link.ready) begin
				if (dut0.loc_link.is_end)
					ends++;
				else
					hs_cyc.push_back(cyc);
			end
			// command port open while the generator still holds a record
			if (cmd_ready && dut0.loc_link.valid)
				ready_busy++;
			if (field_valid) begin
				got_field.push_back(field);
				got_hv.push_back(field_hv_offset);
				if (hs_cyc.size() > 0)
					got_lat.push_back(cyc - hs_cyc.pop_front());
				else
					got_lat.push_back(-1);
			end
			if (done_valid)
				got_done.push_back(done_pkt_id);
		end
	end

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic int rand_bits(int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return r;
	endfunction

	function automatic word_t fill_word(int s, int i);
		return {6'h2a, slot_t'(s), 2'b01, word_idx_t'(i), 8'(i) ^ 8'hc3, slot_t'(s),
			word_idx_t'(i)};
	endfunction

	// bytes pos..pos+3 of a slot, byte 0 is the top byte of word 0
	function automatic word_t model_field(int s, int pos);
		word_t w;
		int b;
		w = '0;
		for (int i = 0; i < 4; i++) begin
			b = pos + i;
			w = {w[23:0], model[s][b / 4][31 - 8 * (b % 4) -: 8]};
		end
		return w;
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic write_header(int s, bit random_fill);
		word_t w;
		for (int i = 0; i < SLOT_WORDS; i++) begin
			w = random_fill ? word_t'(rand_bits(32)) : fill_word(s, i);
			model[s][i] = w;
			hdr_valid = 1'b1;
			hdr_data = w;
			hdr_slot = slot_t'(s);
			hdr_last = (i == SLOT_WORDS - 1);
			@(posedge clk);
			#1;
		end
		hdr_valid = 1'b0;
		hdr_last = 1'b0;
	endtask

	// leaves cmd_valid high so the caller can offer the next command at once
	task automatic send_cmd(int s, int id, int start, int n, int base);
		cmd_valid = 1'b1;
		cmd_slot = slot_t'(s);
		cmd_pkt_id = pkt_id_t'(id);
		cmd_start = byte_pos_t'(start);
		cmd_count = field_count_t'(n);
		cmd_hv_base = hv_offset_t'(base);
		do
			@(posedge clk);
		while (!cmd_ready);
		#1;
		for (int i = 0; i < n; i++) begin
			exp_field.push_back(model_field(s, start + 4 * i));
			exp_hv.push_back(hv_offset_t'(base + i));
		end
		exp_done.push_back(pkt_id_t'(id));
	endtask

	task automatic wait_done();
		while (got_done.size() < exp_done.size())
			@(posedge clk);
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic finish_test(string name);
		int n;
		wait_done();
		check_value("field count", got_field.size(), exp_field.size());
		n = (got_field.size() < exp_field.size()) ? got_field.size() : exp_field.size();
		for (int i = 0; i < n; i++) begin
			check_value("field", got_field[i], exp_field[i]);
			check_value("field_hv_offset", 32'(got_hv[i]), 32'(exp_hv[i]));
			// set on the third edge after the handshake, sampled on the fourth
			check_value("field latency", got_lat[i], 4);
		end
		check_value("done count", got_done.size(), exp_done.size());
		n = (got_done.size() < exp_done.size()) ? got_done.size() : exp_done.size();
		for (int i = 0; i < n; i++)
			check_value("done_pkt_id", 32'(got_done[i]), 32'(exp_done[i]));
		exp_field.delete();
		got_field.delete();
		exp_hv.delete();
		got_hv.delete();
		got_lat.delete();
		exp_done.delete();
		got_done.delete();
		tests++;
		if (errors == err_base)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_base);
		err_base = errors;
	endtask

	task automatic test_reset();
		repeat (2) begin
			@(posedge clk);
			check_value("field_valid", 32'(field_valid), 0);
			check_value("done_valid", 32'(done_valid), 0);
		end
		assert (cmd_ready) else begin
			$display("cmd_ready did not rise within two cycles of reset");
			errors++;
		end
		#1;
		finish_test("reset");
	endtask

	task automatic test_aligned();
		send_cmd(0, 17, 8, 1, 5);
		cmd_valid = 1'b0;
		finish_test("aligned");
	endtask

	task automatic test_straddle();
		for (int off = 1; off < 4; off++)
			send_cmd(1, 32 + off, 17 * off, 1, 10 + off);
		cmd_valid = 1'b0;
		finish_test("straddle");
	endtask

	task automatic test_multi();
		send_cmd(2, 48, 12, 8, 40);
		cmd_valid = 1'b0;
		finish_test("multi_field");
	endtask

	task automatic test_back_to_back();
		int r0;
		int e0;
		r0 = ready_busy;
		e0 = ends;
		for (int k = 0; k < 4; k++)
			send_cmd((k + 3) % 4, 64 + k, 5 * k, 3, 20 * k);
		cmd_valid = 1'b0;
		wait_done();
		check_value("cmd_ready while busy", ready_busy - r0, 0);
		check_value("end records", ends - e0, 4);
		finish_test("back_to_back");
	endtask

	task automatic test_random();
		int s;
		int n;
		int start;
		int base;
		int id;
		for (int k = 0; k < NUM_SLOTS; k++)
			write_header(k, 1'b1);
		for (int k = 0; k < 20; k++) begin
			s = rand_bits(2);
			n = 1 + rand_bits(5);
			// keeps start + 4n + 3 inside the 256-byte header
			start = rand_bits(8) % (253 - 4 * n);
			base = rand_bits(7);
			id = rand_bits(8);
			send_cmd(s, id, start, n, base);
		end
		cmd_valid = 1'b0;
		finish_test("random");
	endtask

	initial begin
		lfsr = 16'd44055;
		cyc = 0;
		errors = 0;
		err_base = 0;
		tests = 0;
		ready_busy = 0;
		ends = 0;
		reset = 1'b0;
		hdr_valid = 1'b0;
		hdr_data = '0;
		hdr_slot = '0;
		hdr_last = 1'b0;
		cmd_valid = 1'b0;
		cmd_slot = '0;
		cmd_pkt_id = '0;
		cmd_start = '0;
		cmd_count = '0;
		cmd_hv_base = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b1;
		test_reset();
		for (int s = 0; s < NUM_SLOTS; s++)
			write_header(s, 1'b0);
		test_aligned();
		test_straddle();
		test_multi();
		test_back_to_back();
		test_random();
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- filelist.f
parser_pkg.sv
extract_cmd_pkg.sv
loc_if.sv
header_buffer.sv
location_gen.sv
field_pipe.sv
extractor_top.sv
tb_extractor.sv

//--- Makefile
# Verilator build and run of the extractor testbench

VERILATOR ?= verilator
TOP ?= tb_extractor
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '*** FAILED ***' $(LOG); then exit 1; fi; \
	if ! grep -qF '*** PASSED ***' $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
